/* fftAccel.f */
+incdir+.
fftDataPkg.sv
fftCtrlPkg.sv
bflyIf.sv
twiddleRom.sv
butterflyUnit.sv
addressGenerator.sv
fftRam.sv
fftControl.sv
fftAccel.sv
fftAccel_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fftAccel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
    --top-module fftAccel_tb -f fftAccel.f -o fftAccelSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/fftAccelSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

/* fftAccel_tb.sv */
`timescale 1ns/10ps
`include "fftAccel_defs.svh"

module fftAccel_tb;

    localparam int frameCount = 8;
    localparam int cycleLimit = frameCount * 200;   // generous per-frame budget
    localparam int impRe = 4096;
    localparam int impIm = -2048;

    logic clk, rst;
    fftDataPkg::sample_t dataIn, dataOut;
    logic dataInValid, loadReady, start, inverse, busy, done;
    logic dataOutValid, dataOutReady;

    integer seed;
    int cycleCount = 0;
    int twRe [8];
    int twIm [8];
    fftDataPkg::sample_t frame [`FFT_POINTS];      // samples sent to the DUT
    fftDataPkg::sample_t expected [`FFT_POINTS];   // model output, natural order

    fftAccel UUT (
        .clk(clk), .rst(rst),
        .dataIn(dataIn), .dataInValid(dataInValid), .loadReady(loadReady),
        .start(start), .inverse(inverse), .busy(busy), .done(done),
        .dataOut(dataOut), .dataOutValid(dataOutValid), .dataOutReady(dataOutReady)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Done: errors found");
            $fatal(1, "timeout, the run did not finish within %0d cycles", cycleLimit);
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expValue);
        if (actual !== expValue) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expValue);
            $display("Done: errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic int roundReal(input real x);
        if (x >= 0.0) return $rtoi(x + 0.5);
        return -$rtoi(-x + 0.5);
    endfunction

    function automatic int bitReverse(input int k);
        return {k[0], k[1], k[2], k[3]};
    endfunction

    function automatic logic [15:0] randPart();
        return 16'(($random(seed) & 16'h3fff) - 8192);   // -8192 .. 8191
    endfunction

    task automatic buildTwiddles();
        real angle;
        real scale;
        scale = $itor(1 << `FFT_FRAC);
        for (int k = 0; k < 8; k++) begin
            angle = 2.0 * 3.14159265358979 * k / 16.0;
            twRe[k] = roundReal(scale * $cos(angle));
            twIm[k] = -roundReal(scale * $sin(angle));
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    task automatic buildExpected(input bit inv);
        int re [16];
        int im [16];
        int half, a, b, tk, wr, wi, tr, ti, ar, ai;
        for (int k = 0; k < 16; k++) begin
            re[bitReverse(k)] = $signed(frame[k][15:0]);
            im[bitReverse(k)] = $signed(frame[k][31:16]);
        end
        for (int s = 0; s < 4; s++) begin
            half = 1 << s;
            for (int j = 0; j < 8; j++) begin
                a  = (j / half) * 2 * half + (j % half);
                b  = a + half;
                tk = (j % half) << (3 - s);
                wr = twRe[tk];
                wi = inv ? -twIm[tk] : twIm[tk];   // conjugate for the inverse
                tr = (re[b] * wr - im[b] * wi) >>> `FFT_FRAC;
                ti = (re[b] * wi + im[b] * wr) >>> `FFT_FRAC;
                ar = re[a];
                ai = im[a];
                re[a] = (ar + tr) >>> 1;
                im[a] = (ai + ti) >>> 1;
                re[b] = (ar - tr) >>> 1;
                im[b] = (ai - ti) >>> 1;
            end
        end
        for (int i = 0; i < 16; i++) begin
            expected[i] = {im[i][15:0], re[i][15:0]};
        end
    endtask

    //////////////////////////////
    // stream drivers
    //////////////////////////////

    task automatic loadFrame();
        int k;
        k = 0;
        @(negedge clk);
        start = 1'b1;                  // must be ignored while idle
        @(negedge clk);
        start = 1'b0;
        checkValue("busy", busy, 1'b0);
        while (k < 16) begin
            @(negedge clk);
            checkValue("loadReady", loadReady, 1'b1);
            if (($random(seed) & 3) == 0) begin
                dataInValid = 1'b0;    // gap
            end else begin
                dataInValid = 1'b1;
                dataIn = frame[k];
                k++;
            end
        end
        @(negedge clk);
        dataIn = ~frame[0];            // extra word offered, must not be taken
        checkValue("loadReady", loadReady, 1'b0);
        @(negedge clk);
        dataInValid = 1'b0;
        checkValue("loadReady", loadReady, 1'b0);
        checkValue("busy", busy, 1'b0);
    endtask

    task automatic runCompute(input bit inv);
        int cycles;
        logic doneSeen;
        cycles = 0;
        doneSeen = 1'b0;
        start = 1'b1;
        inverse = inv;
        while (!doneSeen && cycles < 40) begin
            @(negedge clk);
            start = 1'b0;
            inverse = ~inv;            // direction is latched at start
            cycles++;
            checkValue("busy", busy, 1'b1);
            doneSeen = done;
        end
        checkValue("done latency", cycles, 33);
        @(negedge clk);
        checkValue("busy", busy, 1'b0);
        checkValue("done", done, 1'b0);
        checkValue("dataOutValid", dataOutValid, 1'b1);
    endtask

    task automatic unloadFrame();
        int n;
        logic holding;
        fftDataPkg::sample_t heldWord;
        n = 0;
        holding = 1'b0;
        heldWord = '0;
        while (n < 16) begin
            @(negedge clk);
            if (holding) begin
                checkValue("dataOutValid", dataOutValid, 1'b1);
                checkValue("dataOut held", dataOut, heldWord);
            end
            dataOutReady = (($random(seed) & 3) != 0);
            holding = 1'b0;
            if (dataOutValid) begin
                if (dataOutReady) begin
                    checkValue("dataOut", dataOut, expected[n]);
                    n++;
                end else begin
                    holding = 1'b1;
                    heldWord = dataOut;
                end
            end
        end
        @(negedge clk);
        dataOutReady = 1'b0;
        checkValue("dataOutValid", dataOutValid, 1'b0);
        checkValue("loadReady", loadReady, 1'b1);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        seed = 20;
        clk = 1'b0;
        rst = 1'b1;
        dataIn = '0;
        dataInValid = 1'b0;
        start = 1'b0;
        inverse = 1'b0;
        dataOutReady = 1'b0;
        buildTwiddles();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        checkValue("loadReady", loadReady, 1'b1);
        checkValue("busy", busy, 1'b0);
        checkValue("done", done, 1'b0);
        checkValue("dataOutValid", dataOutValid, 1'b0);

        for (int f = 0; f < frameCount; f++) begin
            if (f == frameCount - 1) begin
                for (int i = 0; i < 16; i++) frame[i] = '0;
                frame[0] = {16'(impIm), 16'(impRe)};   // single impulse at index 0
            end else begin
                for (int i = 0; i < 16; i++) frame[i] = {randPart(), randPart()};
            end
            buildExpected(f[0]);   // odd frames run the inverse
            if (f == frameCount - 1) begin
                for (int i = 0; i < 16; i++) begin
                    checkValue("impulse model", expected[i],
                               {16'(impIm / 16), 16'(impRe / 16)});
                end
            end
            loadFrame();
            runCompute(f[0]);
            unloadFrame();
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

/* fftAccel.sv */
`timescale 1ns/10ps

module fftAccel (
    input logic clk,
    input logic rst,
    input fftDataPkg::sample_t dataIn,
    input logic dataInValid,
    output logic loadReady,
    input logic start,
    input logic inverse,
    output logic busy,
    output logic done,
    output fftDataPkg::sample_t dataOut,
    output logic dataOutValid,
    input logic dataOutReady
);

    fftCtrlPkg::stage_t stage;
    fftCtrlPkg::bflyCount_t bflyCount;
    fftDataPkg::index_t ioIndex;         // load / unload address from control
    fftDataPkg::index_t genA, genB;      // butterfly addresses
    fftDataPkg::index_t ramIndexA;
    fftDataPkg::twIndex_t twIndex;
    logic loadWrite, calcWrite, calcPhase, isInverse;

    bflyIf bflyBus ();

    // port A follows the host stream outside the compute phase
    assign ramIndexA = calcPhase ? genA : ioIndex;

    fftControl iCtrl (
        .clk(clk), .rst(rst),
        .dataInValid(dataInValid), .start(start), .inverse(inverse),
        .dataOutReady(dataOutReady),
        .loadReady(loadReady), .busy(busy), .done(done), .dataOutValid(dataOutValid),
        .isInverse(isInverse), .stage(stage), .bflyCount(bflyCount), .ioIndex(ioIndex),
        .loadWrite(loadWrite), .calcWrite(calcWrite), .calcPhase(calcPhase)
    );

    addressGenerator iAgen (
        .stage(stage), .bflyCount(bflyCount),
        .indexA(genA), .indexB(genB), .twIndex(twIndex)
    );

    twiddleRom iRom (.twIndex(twIndex), .isInverse(isInverse), .tw(bflyBus));

    fftRam iRam (
        .clk(clk), .rst(rst),
        .indexA(ramIndexA), .indexB(genB),
        .loadWrite(loadWrite), .calcWrite(calcWrite),
        .loadData(dataIn), .bus(bflyBus), .readData(dataOut)
    );

    butterflyUnit iBfly (.bus(bflyBus));

endmodule

/* fftControl.sv */
`timescale 1ns/10ps
`include "fftAccel_defs.svh"

module fftControl (
    input logic clk,
    input logic rst,
    input logic dataInValid,
    input logic start,
    input logic inverse,
    input logic dataOutReady,
    output logic loadReady,
    output logic busy,
    output logic done,
    output logic dataOutValid,
    output logic isInverse,
    output fftCtrlPkg::stage_t stage,
    output fftCtrlPkg::bflyCount_t bflyCount,
    output fftDataPkg::index_t ioIndex,
    output logic loadWrite,
    output logic calcWrite,
    output logic calcPhase
);

    fftCtrlPkg::ctrlState_t state;
    fftDataPkg::index_t ioCount;      // shared load / unload word counter
    fftDataPkg::index_t revIndex;     // bit-reversed load address
    logic unloadXfer;
    logic lastBfly;

    assign loadReady    = (state == fftCtrlPkg::idle);
    assign calcPhase    = (state == fftCtrlPkg::calc);
    assign dataOutValid = (state == fftCtrlPkg::unload);
    assign busy         = calcPhase;   // covers the done cycle too

    assign loadWrite  = loadReady & dataInValid;
    assign unloadXfer = dataOutValid & dataOutReady;
    assign calcWrite  = calcPhase & ~done;
    assign lastBfly   = (stage == fftCtrlPkg::stage_t'(`FFT_STAGES - 1)) & (&bflyCount);

    always_comb begin
        for (int i = 0; i < `FFT_ADDR_W; i++) begin
            revIndex[i] = ioCount[`FFT_ADDR_W-1-i];
        end
    end

    assign ioIndex = dataOutValid ? ioCount : revIndex;   // natural order out

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= fftCtrlPkg::idle;
            isInverse <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= calcWrite & lastBfly;   // one cycle after the final write
            case (state)
                fftCtrlPkg::idle:
                    if (loadWrite && (&ioCount)) state <= fftCtrlPkg::loaded;
                fftCtrlPkg::loaded:
                    if (start) begin
                        state     <= fftCtrlPkg::calc;
                        isInverse <= inverse;   // direction fixed for the frame
                    end
                fftCtrlPkg::calc:
                    if (done) state <= fftCtrlPkg::unload;
                default:
                    if (unloadXfer && (&ioCount)) state <= fftCtrlPkg::idle;
            endcase
        end
    end

    //////////////////////////////
    // counters
    //////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ioCount   <= '0;
            stage     <= '0;
            bflyCount <= '0;
        end else begin
            if (loadWrite || unloadXfer) ioCount <= ioCount + 1'b1;   // wraps to 0 at 16
            if (calcWrite) begin
                bflyCount <= bflyCount + 1'b1;
                if (&bflyCount) stage <= stage + 1'b1;   // wraps after stage 3
            end
        end
    end

endmodule

/* fftRam.sv */
`timescale 1ns/10ps
`include "fftAccel_defs.svh"

module fftRam (
    input logic clk,
    input logic rst,
    input fftDataPkg::index_t indexA,
    input fftDataPkg::index_t indexB,
    input logic loadWrite,
    input logic calcWrite,
    input fftDataPkg::sample_t loadData,
    bflyIf.mem bus,
    output fftDataPkg::sample_t readData
);

    fftDataPkg::sample_t mem [`FFT_POINTS];   // in-place sample store
    fftDataPkg::sample_t portAData;

    // port A takes host data while loading, butterfly A' while computing
    assign portAData = loadWrite ? loadData : bus.aOut;

    //////////////////////////////
    // write ports
    //////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FFT_POINTS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (loadWrite || calcWrite) begin
                mem[indexA] <= portAData;
            end
            if (calcWrite) begin
                mem[indexB] <= bus.bOut;   // indexA and indexB never collide here
            end
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    assign bus.aIn  = mem[indexA];
    assign bus.bIn  = mem[indexB];
    assign readData = mem[indexA];   // unload word

endmodule

/* addressGenerator.sv */
`timescale 1ns/10ps

module addressGenerator (
    input fftCtrlPkg::stage_t stage,
    input fftCtrlPkg::bflyCount_t bflyCount,
    output fftDataPkg::index_t indexA,
    output fftDataPkg::index_t indexB,
    output fftDataPkg::twIndex_t twIndex
);

    fftDataPkg::index_t half;    // butterfly span, 2^stage
    fftDataPkg::index_t jExt;    // butterfly count at address width
    fftDataPkg::index_t low;     // position inside the group

    assign jExt = fftDataPkg::index_t'(bflyCount);
    assign half = fftDataPkg::index_t'(1) << stage;
    assign low  = jExt & (half - 1'b1);

    // group base is (j / half) * 2 * half
    assign indexA = ((jExt >> stage) << (stage + 1)) | low;
    assign indexB = indexA | half;   // partner sits one span higher

    // twiddle step shrinks as the span grows
    assign twIndex = fftDataPkg::twIndex_t'(low << (3 - stage));

endmodule

/* butterflyUnit.sv */
`timescale 1ns/10ps
`include "fftAccel_defs.svh"

module butterflyUnit (
    bflyIf.bfly bus
);

    fftDataPkg::part_t aRe, aIm, bRe, bIm, wRe, wIm;
    logic signed [31:0] pRR, pII, pRI, pIR;      // partial products
    logic signed [32:0] prodRe, prodIm;          // full precision B*W
    logic signed [16:0] tRe, tIm;                // B*W back at sample scale
    logic signed [16:0] sumRe, sumIm;
    logic signed [16:0] difRe, difIm;

    //////////////////////////////
    // operand split
    //////////////////////////////

    assign aRe = bus.aIn[15:0];
    assign aIm = bus.aIn[31:16];
    assign bRe = bus.bIn[15:0];
    assign bIm = bus.bIn[31:16];
    assign wRe = bus.tw[15:0];
    assign wIm = bus.tw[31:16];

    //////////////////////////////
    // complex multiply t = B*W
    //////////////////////////////

    assign pRR = bRe * wRe;
    assign pII = bIm * wIm;
    assign pRI = bRe * wIm;
    assign pIR = bIm * wRe;

    assign prodRe = pRR - pII;
    assign prodIm = pRI + pIR;

    assign tRe = 17'(prodRe >>> `FFT_FRAC);     // truncating, not rounding
    assign tIm = 17'(prodIm >>> `FFT_FRAC);

    // A +/- t at 17 bits, then halved so every stage scales by 1/2
    assign sumRe = aRe + tRe;
    assign sumIm = aIm + tIm;
    assign difRe = aRe - tRe;
    assign difIm = aIm - tIm;

    assign bus.aOut = {sumIm[16:1], sumRe[16:1]};
    assign bus.bOut = {difIm[16:1], difRe[16:1]};

endmodule

/* twiddleRom.sv */
`timescale 1ns/10ps
`include "fftAccel_defs.svh"

module twiddleRom (
    input fftDataPkg::twIndex_t twIndex,
    input logic isInverse,
    bflyIf.rom tw
);

    fftDataPkg::part_t wRe;   // cos term
    fftDataPkg::part_t wIm;   // -sin term, forward direction

    // W^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), rounded to Q1.14
    always_comb begin
        case (twIndex)
            3'd0: begin wRe = fftDataPkg::part_t'(1 << `FFT_FRAC); wIm = 16'sd0; end
            3'd1: begin wRe = 16'sd15137; wIm = -16'sd6270; end
            3'd2: begin wRe = 16'sd11585; wIm = -16'sd11585; end
            3'd3: begin wRe = 16'sd6270; wIm = -16'sd15137; end
            3'd4: begin wRe = 16'sd0; wIm = -16'sd16384; end
            3'd5: begin wRe = -16'sd6270; wIm = -16'sd15137; end
            3'd6: begin wRe = -16'sd11585; wIm = -16'sd11585; end
            default: begin wRe = -16'sd15137; wIm = -16'sd6270; end
        endcase
    end

    // the inverse transform runs on the conjugate factors
    assign tw.tw = {isInverse ? -wIm : wIm, wRe};

endmodule

/* bflyIf.sv */
`timescale 1ns/10ps

interface bflyIf;

    fftDataPkg::sample_t aIn;    // operand A from memory
    fftDataPkg::sample_t bIn;    // operand B from memory
    fftDataPkg::twiddle_t tw;    // twiddle factor from rom
    fftDataPkg::sample_t aOut;   // A' back to memory
    fftDataPkg::sample_t bOut;   // B' back to memory

    modport mem (
        output aIn, bIn,
        input  aOut, bOut
    );

    modport bfly (
        input  aIn, bIn, tw,
        output aOut, bOut
    );

    modport rom (
        output tw
    );

endinterface

/* fftCtrlPkg.sv */
`include "fftAccel_defs.svh"

package fftCtrlPkg;

    typedef enum logic [1:0] {
        idle,     // accepting samples from the host
        loaded,   // frame complete, waiting for start
        calc,     // butterflies running, then the done cycle
        unload    // streaming results back out
    } ctrlState_t;

    typedef logic [$clog2(`FFT_STAGES)-1:0] stage_t;      // current stage
    typedef logic [`FFT_ADDR_W-2:0] bflyCount_t;          // butterfly within a stage

endpackage

/* fftDataPkg.sv */
`include "fftAccel_defs.svh"

package fftDataPkg;

    // complex word, real part in [15:0], imaginary part in [31:16]
    typedef logic [31:0] sample_t;
    typedef logic signed [15:0] part_t;        // one signed component
    typedef logic [31:0] twiddle_t;            // Q1.14 pair, same layout as a sample

    typedef logic [`FFT_ADDR_W-1:0] index_t;   // sample memory address
    typedef logic [`FFT_ADDR_W-2:0] twIndex_t; // twiddle table entry

endpackage

/* fftAccel_defs.svh */
`ifndef FFTACCEL_DEFS_SVH
`define FFTACCEL_DEFS_SVH

//////////////////////////////
// transform geometry
//////////////////////////////

`define FFT_POINTS 16   // transform length
`define FFT_ADDR_W 4    // sample memory index width
`define FFT_STAGES 4    // radix-2 stages, log2 of the length

//////////////////////////////
// fixed point
//////////////////////////////

`define FFT_FRAC 14     // twiddle fraction bits, Q1.14

`endif
